// ==== verilog.f ====
verilog/apu_pkg.sv
verilog/apu_register_bank.sv
verilog/apu_frame_sequencer.sv
verilog/apu_envelope.sv
verilog/apu_length_counter.sv
verilog/apu_pulse.sv
verilog/apu_mixer.sv
verilog/apu_pulse_top.sv
dv/apu_pulse_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= apu_pulse_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/apu_pulse_tb.sv ====
`timescale 1ns/1ps

module apu_pulse_tb;

	localparam int NUM_CH = 2;
	localparam int TICK_DIV = 2;
	localparam int QFRAME_TICKS = 64;
	localparam int VOL_W = apu_pkg::VOL_W;
	localparam int TIMER_W = apu_pkg::TIMER_W;
	localparam int ADDR_W = apu_pkg::ADDR_W;
	localparam int DATA_W = apu_pkg::DATA_W;
	localparam int MIX_W = VOL_W + $clog2(NUM_CH);
	localparam int QF_CYCLES = TICK_DIV * QFRAME_TICKS;
	localparam int HF_CYCLES = 2 * QF_CYCLES;
	localparam logic [ADDR_W-1:0] EN_ADDR = ADDR_W'(4 * NUM_CH);
	localparam logic [DATA_W-1:0] ALL_ON = DATA_W'((1 << NUM_CH) - 1);
	localparam logic [31:0] SEED = 32'hae27_d281;

	// Wait limits in sys cycles
	localparam int RISE_LIMIT = 2000;
	localparam int START_LIMIT = 1000;
	localparam int DECAY_LIMIT = 12000;
	localparam int MIX_LIMIT = 2000;
	localparam int SETTLE_CYCLES = 4 * QF_CYCLES;

	logic sys_clk;
	logic sys_rst_n;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [VOL_W-1:0] ch_out [NUM_CH];
	logic [NUM_CH-1:0] ch_act;
	logic [MIX_W-1:0] mix;

	apu_pulse_top #(
		.NUM_CHANNELS (NUM_CH),
		.TICK_DIV     (TICK_DIV),
		.QFRAME_TICKS (QFRAME_TICKS)
	) apu_pulse_top_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.ch_out    (ch_out),
		.ch_act    (ch_act),
		.mix       (mix)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// Expected values
	function automatic int ref_high_steps(input int duty);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			if (apu_pkg::duty_table[duty][i])
				n++;
		return n;
	endfunction

	function automatic int ref_length_hframes(input int idx);
		return int'(apu_pkg::length_table[idx]);
	endfunction

	// Channel 0 loses one more on a negate sweep
	function automatic logic [TIMER_W-1:0] ref_sweep_period(input logic [TIMER_W-1:0] p,
			input int shift, input bit ones_comp);
		logic [TIMER_W-1:0] delta;
		delta = p >> shift;
		if (ones_comp)
			return p - delta - TIMER_W'(1);
		return p - delta;
	endfunction

	function automatic logic [MIX_W-1:0] ref_mix(input logic [VOL_W-1:0] outs [NUM_CH]);
		logic [MIX_W-1:0] total;
		total = '0;
		for (int i = 0; i < NUM_CH; i++)
			total = total + MIX_W'(outs[i]);
		return total;
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input int ch, input logic [1:0] idx);
		return ADDR_W'(4 * ch + int'(idx));
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_level(input string name, input logic [MIX_W-1:0] exp,
			input logic [MIX_W-1:0] act);
		if (act !== exp) begin
			$display("error: %s expected %0d actual %0d", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "level mismatch");
		end
	endtask

	task automatic check_period(input string name, input logic [TIMER_W-1:0] exp,
			input logic [TIMER_W-1:0] act);
		if (act !== exp) begin
			$display("error: %s expected %0d actual %0d", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "period mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("error: %s expected %0d actual %0d", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge sys_clk);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge sys_clk);
		wr_en = 1'b0;
	endtask

	// Returns on the first cycle the new note is in effect
	task automatic program_channel(input int ch, input logic [7:0] ctrl, input logic [7:0] sweep,
			input logic [TIMER_W-1:0] period, input logic [4:0] idx);
		bus_write(reg_addr(ch, apu_pkg::REG_CTRL), ctrl);
		bus_write(reg_addr(ch, apu_pkg::REG_SWEEP), sweep);
		bus_write(reg_addr(ch, apu_pkg::REG_TLO), period[7:0]);
		bus_write(reg_addr(ch, apu_pkg::REG_THI), {idx, period[10:8]});
		@(negedge sys_clk);
	endtask

	// Cycles until the channel output next goes from zero to non-zero
	task automatic wait_rise(input int ch, output int cycles);
		logic [VOL_W-1:0] prev;
		bit found;
		prev = ch_out[ch];
		cycles = 0;
		found = 1'b0;
		while (!found) begin
			@(negedge sys_clk);
			cycles++;
			found = (prev == '0) && (ch_out[ch] != '0);
			prev = ch_out[ch];
			if (!found && cycles >= RISE_LIMIT)
				fail_run("timeout waiting for a rising edge on a channel output");
		end
	endtask

	task automatic test_reset;
		for (int c = 0; c < NUM_CH; c++) begin
			check_level("ch_out after reset", '0, MIX_W'(ch_out[c]));
			check_level("ch_act after reset", '0, MIX_W'(ch_act[c]));
		end
		check_level("mix after reset", '0, mix);
		// Notes stay silent while the enable register is clear
		for (int c = 0; c < NUM_CH; c++)
			program_channel(c, {2'd3, 1'b1, 1'b1, 4'd15}, 8'h00, 11'd10, 5'd1);
		repeat (3 * QF_CYCLES) begin
			@(negedge sys_clk);
			for (int c = 0; c < NUM_CH; c++) begin
				check_level("ch_out while disabled", '0, MIX_W'(ch_out[c]));
				check_level("ch_act while disabled", '0, MIX_W'(ch_act[c]));
			end
			check_level("mix while disabled", '0, mix);
		end
	endtask

	task automatic test_duty(input int ch);
		int duty;
		int vol;
		int p;
		int high;
		duty = $urandom_range(0, 3);
		vol = $urandom_range(1, 15);
		p = $urandom_range(8, 40);
		program_channel(ch, {2'(duty), 1'b1, 1'b1, 4'(vol)}, 8'h00, TIMER_W'(p),
			5'($urandom_range(0, 31)));
		high = 0;
		repeat (8 * (p + 1) * TICK_DIV) begin
			if (ch_out[ch] != '0) begin
				high++;
				check_level("duty high level", MIX_W'(vol), MIX_W'(ch_out[ch]));
			end
			@(negedge sys_clk);
		end
		check_count("duty high cycles", ref_high_steps(duty) * (p + 1) * TICK_DIV, high);
	endtask

	task automatic test_mute;
		program_channel(0, {2'd3, 1'b1, 1'b1, 4'd12}, 8'h00, 11'd5, 5'd0);
		repeat (4 * 8 * 6 * TICK_DIV) begin
			check_level("muted output", '0, MIX_W'(ch_out[0]));
			check_level("muted channel active", MIX_W'(1), MIX_W'(ch_act[0]));
			@(negedge sys_clk);
		end
	endtask

	task automatic test_sweep(input int ch);
		int p;
		int shift;
		int gap;
		int orig;
		int guard;
		logic [TIMER_W-1:0] exp_p;
		p = $urandom_range(20, 40);
		shift = $urandom_range(1, 3);
		program_channel(ch, {2'd2, 1'b1, 1'b1, 4'd10}, {1'b1, 3'd7, 1'b1, 3'(shift)},
			TIMER_W'(p), 5'd0);
		orig = 8 * (p + 1) * TICK_DIV;
		wait_rise(ch, gap);
		gap = orig;
		guard = 0;
		// Skip waveforms until one is cut short by the sweep
		while (gap == orig) begin
			wait_rise(ch, gap);
			guard++;
			if (guard > 40)
				fail_run("sweep never changed the waveform period");
		end
		wait_rise(ch, gap);
		exp_p = ref_sweep_period(TIMER_W'(p), shift, ch == 0);
		check_period("swept period", exp_p, TIMER_W'(gap / (8 * TICK_DIV) - 1));
		check_count("swept waveform cycles", 8 * (int'(exp_p) + 1) * TICK_DIV, gap);
	endtask

	task automatic test_mixer;
		int vols [NUM_CH];
		int total;
		int p;
		int n;
		p = $urandom_range(8, 30);
		total = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			vols[c] = $urandom_range(1, 15);
			total += vols[c];
			bus_write(reg_addr(c, apu_pkg::REG_CTRL), {2'd1, 1'b1, 1'b1, 4'(vols[c])});
			bus_write(reg_addr(c, apu_pkg::REG_SWEEP), 8'h00);
			bus_write(reg_addr(c, apu_pkg::REG_TLO), 8'(p));
		end
		for (int c = 0; c < NUM_CH; c++)
			bus_write(reg_addr(c, apu_pkg::REG_THI), {5'd3, 3'd0});
		n = 0;
		while (mix != MIX_W'(total)) begin
			@(negedge sys_clk);
			n++;
			if (n > MIX_LIMIT)
				fail_run("mix never reached the sum of both channel volumes");
		end
		repeat (1000) @(negedge sys_clk);
	endtask

	task automatic test_envelope(input int ch);
		int e;
		int n;
		int zero_run;
		logic [VOL_W-1:0] last;
		e = $urandom_range(0, 3);
		program_channel(ch, {2'd3, 1'b0, 1'b0, 4'(e)}, 8'h00, 11'd12, 5'd1);
		n = 0;
		while (ch_out[ch] != 4'd15) begin
			@(negedge sys_clk);
			n++;
			if (n > START_LIMIT)
				fail_run("envelope never restarted at full volume");
		end
		last = 4'd15;
		zero_run = 0;
		n = 0;
		while (zero_run < SETTLE_CYCLES) begin
			@(negedge sys_clk);
			n++;
			if (n > DECAY_LIMIT)
				fail_run("envelope did not decay to zero");
			if (ch_out[ch] == '0) begin
				zero_run++;
			end else begin
				zero_run = 0;
				if (ch_out[ch] > last)
					check_level("envelope decay", MIX_W'(last), MIX_W'(ch_out[ch]));
				last = ch_out[ch];
			end
		end
	endtask

	task automatic test_length(input int ch);
		int idx;
		int n;
		int limit;
		idx = $urandom_range(0, 31);
		program_channel(ch, {2'd2, 1'b0, 1'b1, 4'd7}, 8'h00, 11'd50, 5'(idx));
		limit = (ref_length_hframes(idx) + 1) * HF_CYCLES;
		n = 0;
		while (ch_act[ch]) begin
			n++;
			if (n > limit)
				fail_run("length counter never expired");
			@(negedge sys_clk);
		end
		check_count("length half frames", ref_length_hframes(idx),
			(n + HF_CYCLES - 1) / HF_CYCLES);
	endtask

	// Step 0 of duty 3 is high, so the output is live when the enable drops
	task automatic test_disable(input int ch);
		program_channel(ch, {2'd3, 1'b1, 1'b1, 4'd9}, 8'h00, 11'd20, 5'd1);
		check_level("active before disable", MIX_W'(1), MIX_W'(ch_act[ch]));
		check_level("ch_out before disable", MIX_W'(9), MIX_W'(ch_out[ch]));
		bus_write(EN_ADDR, ALL_ON & ~DATA_W'(1 << ch));
		@(negedge sys_clk);
		check_level("ch_act after disable", '0, MIX_W'(ch_act[ch]));
		check_level("ch_out after disable", '0, MIX_W'(ch_out[ch]));
		bus_write(EN_ADDR, ALL_ON);
	endtask

	// Mix must follow the channel outputs of the cycle before
	initial begin : mix_compare
		logic [MIX_W-1:0] prev_sum;
		prev_sum = '0;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n)
				check_level("mixer sum", prev_sum, mix);
			prev_sum = ref_mix(ch_out);
		end
	end

	initial begin
		void'($urandom(SEED));
		sys_rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		test_reset();
		bus_write(EN_ADDR, ALL_ON);
		for (int c = 0; c < NUM_CH; c++) begin
			test_duty(c);
			test_duty(c);
		end
		test_mute();
		for (int c = 0; c < NUM_CH; c++)
			test_sweep(c);
		test_mixer();
		test_envelope($urandom_range(0, NUM_CH - 1));
		for (int c = 0; c < NUM_CH; c++)
			test_length(c);
		for (int c = 0; c < NUM_CH; c++)
			test_disable(c);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== verilog/apu_pulse_top.sv ====
`timescale 1ns/1ps

module apu_pulse_top #(
	parameter int NUM_CHANNELS = 2,
	parameter int TICK_DIV = 2,
	parameter int QFRAME_TICKS = 64
) (
	input  logic                                          sys_clk,
	input  logic                                          sys_rst_n,
	input  logic                                          wr_en,
	input  logic [apu_pkg::ADDR_W-1:0]                    wr_addr,
	input  logic [apu_pkg::DATA_W-1:0]                    wr_data,
	output logic [apu_pkg::VOL_W-1:0]                     ch_out [NUM_CHANNELS],
	output logic [NUM_CHANNELS-1:0]                       ch_act,
	output logic [apu_pkg::VOL_W+$clog2(NUM_CHANNELS)-1:0] mix
);

	logic [apu_pkg::DATA_W-1:0] ctrl_reg [NUM_CHANNELS];
	logic [apu_pkg::DATA_W-1:0] sweep_reg [NUM_CHANNELS];
	logic [apu_pkg::DATA_W-1:0] tlo_reg [NUM_CHANNELS];
	logic [apu_pkg::DATA_W-1:0] thi_reg [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] sweep_wr;
	logic [NUM_CHANNELS-1:0] note_wr;
	logic [NUM_CHANNELS-1:0] ch_en;
	logic apu_tick;
	logic qframe;
	logic hframe;

	apu_register_bank #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) register_bank_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.ctrl_reg  (ctrl_reg),
		.sweep_reg (sweep_reg),
		.tlo_reg   (tlo_reg),
		.thi_reg   (thi_reg),
		.sweep_wr  (sweep_wr),
		.note_wr   (note_wr),
		.ch_en     (ch_en)
	);

	apu_frame_sequencer #(
		.TICK_DIV     (TICK_DIV),
		.QFRAME_TICKS (QFRAME_TICKS)
	) frame_sequencer_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.apu_tick  (apu_tick),
		.qframe    (qframe),
		.hframe    (hframe)
	);

	// Channel 0 keeps the one's-complement sweep negate
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
		apu_pulse #(
			.sweep_defect (i == 0)
		) pulse_inst (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.apu_tick  (apu_tick),
			.qframe    (qframe),
			.hframe    (hframe),
			.ctrl_reg  (ctrl_reg[i]),
			.sweep_reg (sweep_reg[i]),
			.tlo_reg   (tlo_reg[i]),
			.thi_reg   (thi_reg[i]),
			.sweep_wr  (sweep_wr[i]),
			.note_wr   (note_wr[i]),
			.enable    (ch_en[i]),
			.out       (ch_out[i]),
			.act       (ch_act[i])
		);
	end

	apu_mixer #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) mixer_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.ch_out    (ch_out),
		.mix       (mix)
	);

endmodule

// ==== verilog/apu_mixer.sv ====
`timescale 1ns/1ps

module apu_mixer #(
	parameter int NUM_CHANNELS = 2
) (
	input  logic                                          sys_clk,
	input  logic                                          sys_rst_n,
	input  logic [apu_pkg::VOL_W-1:0]                     ch_out [NUM_CHANNELS],
	output logic [apu_pkg::VOL_W+$clog2(NUM_CHANNELS)-1:0] mix
);

	localparam int MIX_W = apu_pkg::VOL_W + $clog2(NUM_CHANNELS);

	logic [MIX_W-1:0] sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_CHANNELS; i++)
			sum = sum + MIX_W'(ch_out[i]);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			mix <= '0;
		else
			mix <= sum;
	end

endmodule

// ==== verilog/apu_pulse.sv ====
`timescale 1ns/1ps

module apu_sweep #(
	parameter bit sweep_defect = 1'b0
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        hframe,
	input  logic                        reload,
	input  logic [apu_pkg::DATA_W-1:0]  sweep_reg,
	input  logic [apu_pkg::TIMER_W-1:0] period,
	output logic [apu_pkg::TIMER_W-1:0] target,
	output logic                        apply,
	output logic                        mute
);

	localparam int TW = apu_pkg::TIMER_W;

	logic sweep_en;
	logic [2:0] div_period;
	logic negate;
	logic [2:0] shift;
	logic [TW-1:0] shifted;
	logic [TW:0] sum;
	logic [2:0] divider;
	logic reload_pending;

	assign sweep_en = sweep_reg[7];
	assign div_period = sweep_reg[6:4];
	assign negate = sweep_reg[3];
	assign shift = sweep_reg[2:0];

	assign shifted = period >> shift;

	// Inverting without the carry-in gives the one's-complement variant
	assign sum = {1'b0, period} + {1'b0, shifted ^ {TW{negate}}}
		+ (TW + 1)'(negate && !sweep_defect);
	assign target = sum[TW-1:0];

	assign mute = (!negate && sum[TW]) || (period < TW'(8));
	assign apply = hframe && (divider == 3'd0) && sweep_en && (shift != 3'd0) && !mute;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			divider <= 3'd0;
			reload_pending <= 1'b0;
		end else begin
			if (reload)
				reload_pending <= 1'b1;
			else if (hframe)
				reload_pending <= 1'b0;
			if (hframe) begin
				if (reload_pending || divider == 3'd0)
					divider <= div_period;
				else
					divider <= divider - 3'd1;
			end
		end
	end

endmodule

module apu_pulse #(
	parameter bit sweep_defect = 1'b0
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       apu_tick,
	input  logic                       qframe,
	input  logic                       hframe,
	input  logic [apu_pkg::DATA_W-1:0] ctrl_reg,
	input  logic [apu_pkg::DATA_W-1:0] sweep_reg,
	input  logic [apu_pkg::DATA_W-1:0] tlo_reg,
	input  logic [apu_pkg::DATA_W-1:0] thi_reg,
	input  logic                       sweep_wr,
	input  logic                       note_wr,
	input  logic                       enable,
	output logic [apu_pkg::VOL_W-1:0]  out,
	output logic                       act
);

	localparam int TW = apu_pkg::TIMER_W;

	logic [1:0] duty;
	logic halt;
	logic const_vol;
	logic [apu_pkg::VOL_W-1:0] env_param;
	logic [4:0] len_idx;
	logic [TW-1:0] note_period;

	logic [TW-1:0] period;
	logic [TW-1:0] timer;
	logic [2:0] step;
	logic [TW-1:0] target;
	logic apply;
	logic mute;
	logic [apu_pkg::VOL_W-1:0] env_vol;
	logic len_gate;
	logic duty_high;

	assign duty = ctrl_reg[7:6];
	assign halt = ctrl_reg[5];
	assign const_vol = ctrl_reg[4];
	assign env_param = ctrl_reg[3:0];
	assign len_idx = thi_reg[7:3];
	assign note_period = {thi_reg[2:0], tlo_reg};

	apu_envelope envelope_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.qframe    (qframe),
		.restart   (note_wr),
		.loop      (halt),
		.const_vol (const_vol),
		.period    (env_param),
		.vol       (env_vol)
	);

	apu_sweep #(
		.sweep_defect (sweep_defect)
	) sweep_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.hframe    (hframe),
		.reload    (sweep_wr),
		.sweep_reg (sweep_reg),
		.period    (period),
		.target    (target),
		.apply     (apply),
		.mute      (mute)
	);

	apu_length_counter length_counter_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.hframe    (hframe),
		.enable    (enable),
		.halt      (halt),
		.load      (note_wr),
		.idx       (len_idx),
		.gate      (len_gate)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			period <= '0;
		else if (note_wr)
			period <= note_period;
		else if (apply)
			period <= target;
	end

	// Sequencer steps downward, one step per timer expiry
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer <= '0;
			step <= 3'd0;
		end else if (note_wr) begin
			timer <= note_period;
			step <= 3'd0;
		end else if (apu_tick) begin
			if (timer == '0) begin
				timer <= period;
				step <= step - 3'd1;
			end else begin
				timer <= timer - 1'b1;
			end
		end
	end

	assign duty_high = apu_pkg::duty_table[duty][step];

	assign out = (enable && len_gate && !mute && duty_high) ? env_vol : '0;
	assign act = len_gate;

endmodule

// ==== verilog/apu_length_counter.sv ====
`timescale 1ns/1ps

module apu_length_counter (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       hframe,
	input  logic       enable,
	input  logic       halt,
	input  logic       load,
	input  logic [4:0] idx,
	output logic       gate
);

	logic [7:0] count;
	logic expired;

	assign expired = count == 8'd0;

	// Disabled channel holds the count at zero and ignores loads
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			count <= 8'd0;
		else if (!enable)
			count <= 8'd0;
		else if (load)
			count <= apu_pkg::length_table[idx];
		else if (hframe && !expired && !halt)
			count <= count - 8'd1;
	end

	assign gate = !expired;

endmodule

// ==== verilog/apu_envelope.sv ====
`timescale 1ns/1ps

module apu_envelope (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      qframe,
	input  logic                      restart,
	input  logic                      loop,
	input  logic                      const_vol,
	input  logic [apu_pkg::VOL_W-1:0] period,
	output logic [apu_pkg::VOL_W-1:0] vol
);

	logic start;
	logic [apu_pkg::VOL_W-1:0] divider;
	logic [apu_pkg::VOL_W-1:0] level;

	// Restart is only armed here, the decay begins on the next quarter frame
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			start <= 1'b0;
		else if (restart)
			start <= 1'b1;
		else if (qframe)
			start <= 1'b0;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			divider <= '0;
			level <= '0;
		end else if (qframe) begin
			if (start) begin
				divider <= period;
				level <= '1;
			end else if (divider == '0) begin
				divider <= period;
				if (level != '0)
					level <= level - 1'b1;
				else if (loop)
					level <= '1;
			end else begin
				divider <= divider - 1'b1;
			end
		end
	end

	assign vol = const_vol ? period : level;

endmodule

// ==== verilog/apu_frame_sequencer.sv ====
`timescale 1ns/1ps

module apu_frame_sequencer #(
	parameter int TICK_DIV = 2,
	parameter int QFRAME_TICKS = 64
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic apu_tick,
	output logic qframe,
	output logic hframe
);

	localparam int DIV_W = TICK_DIV > 1 ? $clog2(TICK_DIV) : 1;
	localparam int QF_W = QFRAME_TICKS > 1 ? $clog2(QFRAME_TICKS) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic [QF_W-1:0] tick_cnt;
	logic half;
	logic tick_now;
	logic qframe_now;

	assign tick_now = div_cnt == DIV_W'(TICK_DIV - 1);
	assign qframe_now = tick_now && (tick_cnt == QF_W'(QFRAME_TICKS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
			tick_cnt <= '0;
			half <= 1'b0;
		end else begin
			div_cnt <= tick_now ? '0 : div_cnt + 1'b1;
			if (qframe_now)
				tick_cnt <= '0;
			else if (tick_now)
				tick_cnt <= tick_cnt + 1'b1;
			// Every second quarter frame is also a half frame
			if (qframe_now)
				half <= ~half;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			apu_tick <= 1'b0;
			qframe <= 1'b0;
			hframe <= 1'b0;
		end else begin
			apu_tick <= tick_now;
			qframe <= qframe_now;
			hframe <= qframe_now && half;
		end
	end

endmodule

// ==== verilog/apu_register_bank.sv ====
`timescale 1ns/1ps

module apu_register_bank #(
	parameter int NUM_CHANNELS = 2
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       wr_en,
	input  logic [apu_pkg::ADDR_W-1:0] wr_addr,
	input  logic [apu_pkg::DATA_W-1:0] wr_data,
	output logic [apu_pkg::DATA_W-1:0] ctrl_reg [NUM_CHANNELS],
	output logic [apu_pkg::DATA_W-1:0] sweep_reg [NUM_CHANNELS],
	output logic [apu_pkg::DATA_W-1:0] tlo_reg [NUM_CHANNELS],
	output logic [apu_pkg::DATA_W-1:0] thi_reg [NUM_CHANNELS],
	output logic [NUM_CHANNELS-1:0]    sweep_wr,
	output logic [NUM_CHANNELS-1:0]    note_wr,
	output logic [NUM_CHANNELS-1:0]    ch_en
);

	localparam int AW = apu_pkg::ADDR_W;
	localparam int CW = apu_pkg::ADDR_W - 2;
	localparam logic [AW-1:0] EN_ADDR = AW'(4 * NUM_CHANNELS);

	logic in_window;
	logic [1:0] reg_sel;

	assign in_window = wr_en && (wr_addr < EN_ADDR);
	assign reg_sel = wr_addr[1:0];

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
		logic hit;

		assign hit = in_window && (wr_addr[AW-1:2] == CW'(i));

		always_ff @(posedge sys_clk or negedge sys_rst_n) begin
			if (!sys_rst_n) begin
				ctrl_reg[i] <= '0;
				sweep_reg[i] <= '0;
				tlo_reg[i] <= '0;
				thi_reg[i] <= '0;
				sweep_wr[i] <= 1'b0;
				note_wr[i] <= 1'b0;
			end else begin
				// Strobes line up with the byte becoming visible
				sweep_wr[i] <= hit && (reg_sel == apu_pkg::REG_SWEEP);
				note_wr[i] <= hit && (reg_sel == apu_pkg::REG_THI);
				if (hit) begin
					case (reg_sel)
						apu_pkg::REG_CTRL: ctrl_reg[i] <= wr_data;
						apu_pkg::REG_SWEEP: sweep_reg[i] <= wr_data;
						apu_pkg::REG_TLO: tlo_reg[i] <= wr_data;
						default: thi_reg[i] <= wr_data;
					endcase
				end
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			ch_en <= '0;
		else if (wr_en && wr_addr == EN_ADDR)
			ch_en <= wr_data[NUM_CHANNELS-1:0];
	end

endmodule

// ==== verilog/apu_pkg.sv ====
package apu_pkg;

	// CPU-side bus
	localparam int ADDR_W = 5;
	localparam int DATA_W = 8;

	// Channel datapath
	localparam int VOL_W = 4;
	localparam int TIMER_W = 11;

	// Register index within a channel's four-byte window
	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_SWEEP = 2'd1;
	localparam logic [1:0] REG_TLO = 2'd2;
	localparam logic [1:0] REG_THI = 2'd3;

	// Note lengths in half frames, indexed by the upper five bits of the high timer byte
	localparam logic [7:0] length_table [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	// Bit n is the output level at sequencer step n
	localparam logic [7:0] duty_table [4] = '{
		8'b1000_0000,
		8'b1100_0000,
		8'b1111_0000,
		8'b0011_1111
	};

endpackage
